// File: hdl/tora_pkg.sv
// Shared constants for the frame services
// Video timing, clock enable ratios, SDRAM and download widths
// ROM slot widths and offsets, slot and arbiter enums

package tora_pkg;

    //////////////////////////////
    // Video timing
    localparam int H_TOTAL       = 384;
    localparam int H_BLANK_START = 256;
    localparam int HS_START      = 296;
    localparam int HS_END        = 328;

    localparam int V_TOTAL       = 262;
    localparam int V_BLANK_START = 240;
    localparam int VS_START      = 244;
    localparam int VS_END        = 248;

    localparam int H_W = 9;
    localparam int V_W = 9;

    // clk cycles per strobe, 48 MHz in
    localparam int PXL2_DIV = 4;
    localparam int PXL_DIV  = 8;

    //////////////////////////////
    // SDRAM and download
    localparam int SDRAM_AW = 22;
    localparam int ROM_DW   = 16;
    localparam int IOCTL_AW = 25;

    //////////////////////////////
    // ROM slots
    localparam int NUM_SLOTS = 4;

    localparam int CHAR_AW   = 14;
    localparam int SCROLL_AW = 19;
    localparam int MAIN_AW   = 17;
    localparam int SOUND_AW  = 15;

    // Word offsets into SDRAM
    localparam int CHAR_OFFSET   = 'h2C000;
    localparam int SCROLL_OFFSET = 'h100000;
    localparam int MAIN_OFFSET   = 0;
    localparam int SOUND_OFFSET  = 'h20000;

    // Highest priority first
    typedef enum logic [1:0] {
        SLOT_MAIN,
        SLOT_SOUND,
        SLOT_CHAR,
        SLOT_SCROLL
    } slot_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

endpackage

// File: hdl/cen_gen.sv
// Pixel clock enables from the 48 MHz clock
// 12 MHz and 6 MHz single-cycle strobes

`timescale 1ns/1ns

module cen_gen import tora_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Free running, wraps every PXL_DIV cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // 6 MHz slot is a subset of the 12 MHz slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= (cnt[1:0] == 2'(PXL2_DIV - 1));
            pxl_cen  <= (cnt == 3'(PXL_DIV - 1));
        end
    end

endmodule

// File: hdl/video_timer.sv
// Horizontal and vertical pixel counters
// Registered blanking and sync levels

`timescale 1ns/1ns

module video_timer import tora_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pxl_cen,
    output logic [H_W-1:0] h,
    output logic [V_W-1:0] v,
    output logic           lhbl,
    output logic           lvbl,
    output logic           hs,
    output logic           vs
);

    logic h_last;
    logic v_last;

    assign h_last = (h == H_W'(H_TOTAL - 1));
    assign v_last = (v == V_W'(V_TOTAL - 1));

    //////////////////////////////
    // Counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                h <= '0;
                // New line
                if (v_last) begin
                    v <= '0;
                end else begin
                    v <= v + 1'b1;
                end
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Blanking and sync windows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl <= 1'b1;
            lvbl <= 1'b1;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else begin
            // Active high while inside the visible area
            lhbl <= (h < H_W'(H_BLANK_START));
            lvbl <= (v < V_W'(V_BLANK_START));
            hs   <= (h >= H_W'(HS_START)) && (h < H_W'(HS_END));
            vs   <= (v >= V_W'(VS_START)) && (v < V_W'(VS_END));
        end
    end

endmodule

// File: hdl/rom_slot.sv
// Single-word ROM cache for one client
// Tag compare for ok, miss request held until the fill strobe

`timescale 1ns/1ns

module rom_slot import tora_pkg::*; #(
    parameter int AW = 14
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cs,
    input  logic [AW-1:0]     addr,
    output logic              ok,
    output logic [ROM_DW-1:0] data,
    output logic              req,
    output logic [AW-1:0]     req_addr,
    input  logic              fill,
    input  logic [ROM_DW-1:0] fill_data
);

    logic [AW-1:0] tag;
    logic          valid;
    logic          hit;

    assign hit = valid && (tag == addr);
    assign ok  = cs && hit;

    // Cached word and its tag
    always_ff @(posedge clk) begin
        if (fill) begin
            data <= fill_data;
            tag  <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else if (fill) begin
            valid <= 1'b1;
            req   <= 1'b0;
        end else if (cs && !hit && !req) begin
            req <= 1'b1;
        end
    end

    // Pending address is captured with the miss
    always_ff @(posedge clk) begin
        if (cs && !hit && !req && !fill) begin
            req_addr <= addr;
        end
    end

endmodule

// File: hdl/rom_arbiter.sv
// Four cached ROM slots sharing one SDRAM read port
// Fixed priority request sequencer with per-slot offsets

`timescale 1ns/1ns

module rom_arbiter import tora_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dwnld_busy,
    input  logic                char_cs,
    input  logic [CHAR_AW-1:0]  char_addr,
    output logic                char_ok,
    output logic [ROM_DW-1:0]   char_data,
    input  logic                scroll_cs,
    input  logic [SCROLL_AW-1:0] scroll_addr,
    output logic                scroll_ok,
    output logic [ROM_DW-1:0]   scroll_data,
    input  logic                main_cs,
    input  logic [MAIN_AW-1:0]  main_addr,
    output logic                main_ok,
    output logic [ROM_DW-1:0]   main_data,
    input  logic                sound_cs,
    input  logic [SOUND_AW-1:0] sound_addr,
    output logic                sound_ok,
    output logic [ROM_DW-1:0]   sound_data,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [ROM_DW-1:0]   data_read
);

    logic [NUM_SLOTS-1:0] slot_req;
    logic [NUM_SLOTS-1:0] slot_fill;
    logic [CHAR_AW-1:0]   char_req_addr;
    logic [SCROLL_AW-1:0] scroll_req_addr;
    logic [MAIN_AW-1:0]   main_req_addr;
    logic [SOUND_AW-1:0]  sound_req_addr;
    arb_state_e           state;
    slot_e                grant;
    slot_e                winner;
    logic [SDRAM_AW-1:0]  win_addr;

    //////////////////////////////
    // Slot caches
    rom_slot #(.AW(MAIN_AW)) u_main_slot (
        .clk(clk), .rst_n(rst_n), .cs(main_cs), .addr(main_addr),
        .ok(main_ok), .data(main_data),
        .req(slot_req[SLOT_MAIN]), .req_addr(main_req_addr),
        .fill(slot_fill[SLOT_MAIN]), .fill_data(data_read)
    );

    rom_slot #(.AW(SOUND_AW)) u_sound_slot (
        .clk(clk), .rst_n(rst_n), .cs(sound_cs), .addr(sound_addr),
        .ok(sound_ok), .data(sound_data),
        .req(slot_req[SLOT_SOUND]), .req_addr(sound_req_addr),
        .fill(slot_fill[SLOT_SOUND]), .fill_data(data_read)
    );

    rom_slot #(.AW(CHAR_AW)) u_char_slot (
        .clk(clk), .rst_n(rst_n), .cs(char_cs), .addr(char_addr),
        .ok(char_ok), .data(char_data),
        .req(slot_req[SLOT_CHAR]), .req_addr(char_req_addr),
        .fill(slot_fill[SLOT_CHAR]), .fill_data(data_read)
    );

    rom_slot #(.AW(SCROLL_AW)) u_scroll_slot (
        .clk(clk), .rst_n(rst_n), .cs(scroll_cs), .addr(scroll_addr),
        .ok(scroll_ok), .data(scroll_data),
        .req(slot_req[SLOT_SCROLL]), .req_addr(scroll_req_addr),
        .fill(slot_fill[SLOT_SCROLL]), .fill_data(data_read)
    );

    //////////////////////////////
    // Winner and its SDRAM address
    always_comb begin
        winner = SLOT_MAIN;
        // Lowest enum value wins, so scan from the bottom of the order
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_req[i]) begin
                winner = slot_e'(i);
            end
        end
    end

    always_comb begin
        case (winner)
            SLOT_SOUND: win_addr = SDRAM_AW'(SOUND_OFFSET) + SDRAM_AW'(sound_req_addr);
            SLOT_CHAR:  win_addr = SDRAM_AW'(CHAR_OFFSET) + SDRAM_AW'(char_req_addr);
            SLOT_SCROLL: win_addr = SDRAM_AW'(SCROLL_OFFSET) + SDRAM_AW'(scroll_req_addr);
            default:    win_addr = SDRAM_AW'(MAIN_OFFSET) + SDRAM_AW'(main_req_addr);
        endcase
    end

    // Fill goes to the granted slot only while the data arrives
    assign slot_fill = (state == ARB_WAIT_DATA && data_rdy) ?
                       (NUM_SLOTS'(1) << grant) : '0;

    //////////////////////////////
    // Request sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            grant     <= SLOT_MAIN;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (!dwnld_busy && |slot_req) begin
                        grant     <= winner;
                        sdram_req <= 1'b1;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Address held with the request until the ack
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && !dwnld_busy && |slot_req) begin
            sdram_addr <= win_addr;
        end
    end

endmodule

// File: hdl/prog_loader.sv
// Download byte stream to SDRAM write words
// Byte lane mask and write strobe held until the SDRAM ack

`timescale 1ns/1ns

module prog_loader import tora_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic                ioctl_wr,
    input  logic [IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                sdram_ack,
    output logic                dwnld_busy,
    output logic [SDRAM_AW-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we
);

    //////////////////////////////
    // Control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwnld_busy <= 1'b0;
            prog_we    <= 1'b0;
        end else begin
            dwnld_busy <= downloading;
            if (ioctl_wr) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                // Write accepted by the SDRAM
                prog_we <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Word address, data and byte mask
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_addr <= SDRAM_AW'(ioctl_addr >> 1);
            prog_data <= ioctl_dout;
            // Active low, even bytes land in the low lane
            if (ioctl_addr[0]) begin
                prog_mask <= 2'b01;
            end else begin
                prog_mask <= 2'b10;
            end
        end
    end

endmodule

// File: hdl/tora_game.sv
// Frame services top level
// Clock enables, video timer, ROM loader and ROM slot arbiter

`timescale 1ns/1ns

module tora_game import tora_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    // Video timing
    output logic                 pxl2_cen,
    output logic                 pxl_cen,
    output logic [H_W-1:0]       h,
    output logic [V_W-1:0]       v,
    output logic                 lhbl,
    output logic                 lvbl,
    output logic                 hs,
    output logic                 vs,
    // ROM download
    input  logic                 downloading,
    input  logic                 ioctl_wr,
    input  logic [IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    output logic                 dwnld_busy,
    output logic [SDRAM_AW-1:0]  prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    // ROM clients
    input  logic                 char_cs,
    input  logic [CHAR_AW-1:0]   char_addr,
    output logic                 char_ok,
    output logic [ROM_DW-1:0]    char_data,
    input  logic                 scroll_cs,
    input  logic [SCROLL_AW-1:0] scroll_addr,
    output logic                 scroll_ok,
    output logic [ROM_DW-1:0]    scroll_data,
    input  logic                 main_cs,
    input  logic [MAIN_AW-1:0]   main_addr,
    output logic                 main_ok,
    output logic [ROM_DW-1:0]    main_data,
    input  logic                 sound_cs,
    input  logic [SOUND_AW-1:0]  sound_addr,
    output logic                 sound_ok,
    output logic [ROM_DW-1:0]    sound_data,
    // SDRAM
    output logic                 sdram_req,
    output logic [SDRAM_AW-1:0]  sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  logic [ROM_DW-1:0]    data_read
);

    cen_gen u_cen (
        .clk(clk), .rst_n(rst_n), .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen)
    );

    video_timer u_timer (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .h(h), .v(v),
        .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs)
    );

    // Shares sdram_ack with the arbiter
    prog_loader u_loader (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
        .sdram_ack(sdram_ack), .dwnld_busy(dwnld_busy), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_mask(prog_mask), .prog_we(prog_we)
    );

    // ROM reads held off while the download is busy
    rom_arbiter u_rom (
        .clk(clk), .rst_n(rst_n), .dwnld_busy(dwnld_busy),
        .char_cs(char_cs), .char_addr(char_addr),
        .char_ok(char_ok), .char_data(char_data),
        .scroll_cs(scroll_cs), .scroll_addr(scroll_addr),
        .scroll_ok(scroll_ok), .scroll_data(scroll_data),
        .main_cs(main_cs), .main_addr(main_addr),
        .main_ok(main_ok), .main_data(main_data),
        .sound_cs(sound_cs), .sound_addr(sound_addr),
        .sound_ok(sound_ok), .sound_data(sound_data),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

endmodule

// File: tests/tora_chk.sv
// Concurrent assertions on the ROM slot arbiter
// SDRAM request hold, fill steering, download gating

`timescale 1ns/1ns

module tora_chk import tora_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 dwnld_busy,
    input logic                 sdram_req,
    input logic [SDRAM_AW-1:0]  sdram_addr,
    input logic                 sdram_ack,
    input logic                 data_rdy,
    input logic [NUM_SLOTS-1:0] slot_req,
    input logic [NUM_SLOTS-1:0] slot_fill,
    input arb_state_e           state
);

    // Request and address hold until the ack
    req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req or sdram_addr changed before sdram_ack");

    // At most one fill, and only into a slot that is still waiting
    fill_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(slot_fill) && ((slot_fill & ~slot_req) == '0))
        else $error("fill pulse on more than one slot or on an idle slot");

    busy_gate_a: assert property (@(posedge clk) disable iff (!rst_n)
        dwnld_busy |-> !sdram_req)
        else $error("sdram_req high during the download");

    // Read data must find the arbiter waiting for it
    rdy_state_a: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy |-> state == ARB_WAIT_DATA)
        else $error("data_rdy arrived outside ARB_WAIT_DATA");

endmodule

bind rom_arbiter tora_chk i_chk (
    .clk(clk), .rst_n(rst_n), .dwnld_busy(dwnld_busy), .sdram_req(sdram_req),
    .sdram_addr(sdram_addr), .sdram_ack(sdram_ack), .data_rdy(data_rdy),
    .slot_req(slot_req), .slot_fill(slot_fill), .state(state)
);

// File: tests/tb_tora.sv
// Directed testbench for the frame services top level
// SDRAM read model, compare tasks and the five directed tests

`timescale 1ns/1ns

module tb_tora import tora_pkg::*; ();

    localparam int WAIT_MAX   = 200;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * PXL_DIV + 64;
    localparam logic [MAIN_AW-1:0] MISS_ADDR = 17'h0ABCD;

    logic                 clk;
    logic                 rst_n;
    logic                 pxl2_cen;
    logic                 pxl_cen;
    logic [H_W-1:0]       h;
    logic [V_W-1:0]       v;
    logic                 lhbl;
    logic                 lvbl;
    logic                 hs;
    logic                 vs;
    logic                 downloading;
    logic                 ioctl_wr;
    logic [IOCTL_AW-1:0]  ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic                 dwnld_busy;
    logic [SDRAM_AW-1:0]  prog_addr;
    logic [7:0]           prog_data;
    logic [1:0]           prog_mask;
    logic                 prog_we;
    logic                 char_cs;
    logic [CHAR_AW-1:0]   char_addr;
    logic                 char_ok;
    logic [ROM_DW-1:0]    char_data;
    logic                 scroll_cs;
    logic [SCROLL_AW-1:0] scroll_addr;
    logic                 scroll_ok;
    logic [ROM_DW-1:0]    scroll_data;
    logic                 main_cs;
    logic [MAIN_AW-1:0]   main_addr;
    logic                 main_ok;
    logic [ROM_DW-1:0]    main_data;
    logic                 sound_cs;
    logic [SOUND_AW-1:0]  sound_addr;
    logic                 sound_ok;
    logic [ROM_DW-1:0]    sound_data;
    logic                 sdram_req;
    logic [SDRAM_AW-1:0]  sdram_addr;
    logic                 sdram_ack;
    logic                 data_rdy;
    logic [ROM_DW-1:0]    data_read;

    // Download ack from the tests, read ack from the model
    logic tb_ack;
    logic model_ack;
    assign sdram_ack = tb_ack | model_ack;

    integer               seed = 32'h48361205;
    int                   err_cnt = 0;
    int                   check_cnt = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    logic [SDRAM_AW-1:0]  served [$];
    slot_e                order [$];
    logic [NUM_SLOTS-1:0] seen;

    tora_game i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word the SDRAM model returns for an address
    function automatic logic [ROM_DW-1:0] model_word(input logic [SDRAM_AW-1:0] a);
        return a[15:0] ^ 16'hA5A5;
    endfunction

    //////////////////////////////
    // SDRAM read model
    initial begin : sdram_model
        int                  ack_dly;
        int                  rdy_dly;
        logic [SDRAM_AW-1:0] a;
        model_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (sdram_req) begin
                ack_dly = {$random(seed)} % 6;
                rdy_dly = 1 + {$random(seed)} % 3;
                repeat (ack_dly) @(negedge clk);
                a = sdram_addr;
                served.push_back(a);
                model_ack = 1'b1;
                @(negedge clk);
                model_ack = 1'b0;
                repeat (rdy_dly - 1) @(negedge clk);
                data_read = model_word(a);
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Compare tasks
    task automatic check_word(input string name, input logic [ROM_DW-1:0] got,
                              input logic [ROM_DW-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic match_addr(input string name, input logic [SDRAM_AW-1:0] got,
                              input logic [SDRAM_AW-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_slot(input string name, input slot_e got, input slot_e exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    task automatic verify_count(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        err_cnt++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, err_cnt - errs_before);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    //////////////////////////////
    // Helpers
    task automatic write_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        match_addr("prog_addr", prog_addr, SDRAM_AW'(a / 2));
        check_word("prog_data", ROM_DW'(prog_data), ROM_DW'(d));
        // Active low lane enable
        check_word("prog_mask", ROM_DW'(prog_mask), a[0] ? ROM_DW'(1) : ROM_DW'(2));
        compare_bit("prog_we", prog_we, 1'b1);
        repeat (4) begin
            @(negedge clk);
            compare_bit("prog_we", prog_we, 1'b1);
            compare_bit("sdram_req", sdram_req, 1'b0);
        end
        tb_ack = 1'b1;
        @(negedge clk);
        tb_ack = 1'b0;
        compare_bit("prog_we", prog_we, 1'b0);
        compare_bit("sdram_req", sdram_req, 1'b0);
    endtask

    task automatic refetch_main(input logic [MAIN_AW-1:0] a);
        int                  base;
        int                  n;
        logic [SDRAM_AW-1:0] exp_a;
        base      = served.size();
        exp_a     = SDRAM_AW'(MAIN_OFFSET) + SDRAM_AW'(a);
        main_addr = a;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!main_ok && n < WAIT_MAX);
        if (!main_ok) begin
            report_timeout("main_ok did not rise after an address change");
        end
        repeat (10) @(negedge clk);
        verify_count("new sdram requests", served.size() - base, 1);
        check_word("main_data", main_data, model_word(exp_a));
    endtask

    task automatic note_service(input logic ok, input slot_e s);
        if (ok && !seen[s]) begin
            seen[s] = 1'b1;
            order.push_back(s);
        end
    endtask

    task automatic measure_period(input bit slow, output int period);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(slow ? pxl_cen : pxl2_cen) && n < WAIT_MAX);
        period = 0;
        do begin
            @(negedge clk);
            period++;
        end while (!(slow ? pxl_cen : pxl2_cen) && period < WAIT_MAX);
    endtask

    //////////////////////////////
    // Directed tests
    task automatic download_mapping();
        int e0;
        e0 = err_cnt;
        // Levels right after reset
        compare_bit("prog_we", prog_we, 1'b0);
        compare_bit("sdram_req", sdram_req, 1'b0);
        compare_bit("main_ok", main_ok, 1'b0);
        compare_bit("lhbl", lhbl, 1'b1);
        compare_bit("lvbl", lvbl, 1'b1);
        compare_bit("hs", hs, 1'b0);
        compare_bit("vs", vs, 1'b0);
        downloading = 1'b1;
        @(negedge clk);
        compare_bit("dwnld_busy", dwnld_busy, 1'b1);
        // A main miss raised now has to wait for the download
        main_addr = MISS_ADDR;
        main_cs   = 1'b1;
        write_byte(25'h0002468, 8'h5A);
        write_byte(25'h0002469, 8'hC3);
        write_byte(25'h1F0000B, 8'h3E);
        @(negedge clk);
        downloading = 1'b0;
        @(negedge clk);
        compare_bit("dwnld_busy", dwnld_busy, 1'b0);
        close_test("download_mapping", e0);
    endtask

    task automatic single_miss();
        int                  e0;
        int                  n;
        logic [SDRAM_AW-1:0] exp_a;
        e0 = err_cnt;
        exp_a = SDRAM_AW'(MAIN_OFFSET) + SDRAM_AW'(MISS_ADDR);
        main_cs   = 1'b1;
        main_addr = MISS_ADDR;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sdram_req && n < WAIT_MAX);
        if (sdram_req) begin
            match_addr("sdram_addr", sdram_addr, exp_a);
        end else begin
            report_timeout("no sdram_req after a main miss");
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!main_ok && n < WAIT_MAX);
        if (!main_ok) begin
            report_timeout("main_ok did not rise after the miss");
        end
        check_word("main_data", main_data, model_word(exp_a));
        close_test("single_miss", e0);
    endtask

    task automatic cache_hit();
        int e0;
        int base;
        e0   = err_cnt;
        base = served.size();
        repeat (20) begin
            @(negedge clk);
            compare_bit("main_ok", main_ok, 1'b1);
        end
        verify_count("requests on a hit", served.size() - base, 0);
        refetch_main(MISS_ADDR + 17'd1);
        refetch_main(MISS_ADDR);
        close_test("cache_hit", e0);
    endtask

    task automatic contention();
        logic [SDRAM_AW-1:0] exp_addr [NUM_SLOTS];
        slot_e               exp_order [NUM_SLOTS];
        int                  e0;
        int                  base;
        int                  n;
        e0   = err_cnt;
        base = served.size();
        // Service order main, sound, char, scroll
        exp_order[0] = SLOT_MAIN;
        exp_order[1] = SLOT_SOUND;
        exp_order[2] = SLOT_CHAR;
        exp_order[3] = SLOT_SCROLL;
        @(negedge clk);
        main_addr   = MAIN_AW'($random(seed));
        sound_addr  = SOUND_AW'($random(seed));
        char_addr   = CHAR_AW'($random(seed));
        scroll_addr = SCROLL_AW'($random(seed));
        exp_addr[0] = SDRAM_AW'(MAIN_OFFSET) + SDRAM_AW'(main_addr);
        exp_addr[1] = SDRAM_AW'(SOUND_OFFSET) + SDRAM_AW'(sound_addr);
        exp_addr[2] = SDRAM_AW'(CHAR_OFFSET) + SDRAM_AW'(char_addr);
        exp_addr[3] = SDRAM_AW'(SCROLL_OFFSET) + SDRAM_AW'(scroll_addr);
        main_cs   = 1'b1;
        sound_cs  = 1'b1;
        char_cs   = 1'b1;
        scroll_cs = 1'b1;
        seen = '0;
        order.delete();
        n = 0;
        do begin
            @(negedge clk);
            n++;
            note_service(main_ok, SLOT_MAIN);
            note_service(sound_ok, SLOT_SOUND);
            note_service(char_ok, SLOT_CHAR);
            note_service(scroll_ok, SLOT_SCROLL);
        end while (seen != '1 && n < 4 * WAIT_MAX);
        if (seen != '1) begin
            report_timeout("not every ROM slot was served");
        end
        verify_count("slots served", order.size(), NUM_SLOTS);
        for (int i = 0; i < order.size(); i++) begin
            expect_slot("service order", order[i], exp_order[i]);
            match_addr("sdram_addr", served[base + i], exp_addr[i]);
        end
        check_word("main_data", main_data, model_word(exp_addr[0]));
        check_word("sound_data", sound_data, model_word(exp_addr[1]));
        check_word("char_data", char_data, model_word(exp_addr[2]));
        check_word("scroll_data", scroll_data, model_word(exp_addr[3]));
        main_cs   = 1'b0;
        sound_cs  = 1'b0;
        char_cs   = 1'b0;
        scroll_cs = 1'b0;
        close_test("contention", e0);
    endtask

    task automatic video_timing();
        int e0;
        int n;
        int period;
        int strobes;
        int lhbl_low;
        int hs_high;
        int lines;
        int lvbl_high;
        int vs_high;
        e0 = err_cnt;
        measure_period(1'b0, period);
        verify_count("pxl2_cen period", period, PXL2_DIV);
        measure_period(1'b1, period);
        verify_count("pxl_cen period", period, PXL_DIV);

        // One line from a frame start, then the whole frame
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(pxl_cen && h == '0 && v == '0) && n < FRAME_CLKS);
        if (!(pxl_cen && h == '0 && v == '0)) begin
            report_timeout("no frame start seen");
        end
        strobes   = 0;
        lhbl_low  = 0;
        hs_high   = 0;
        lines     = 0;
        lvbl_high = 0;
        vs_high   = 0;
        n = 0;
        while (lines < V_TOTAL && n < FRAME_CLKS) begin
            if (pxl_cen) begin
                if (lines == 0) begin
                    strobes++;
                    lhbl_low += int'(!lhbl);
                    hs_high  += int'(hs);
                end
                if (h == '0) begin
                    lvbl_high += int'(lvbl);
                    vs_high   += int'(vs);
                end
                if (h == H_W'(H_TOTAL - 1)) begin
                    lines++;
                end
            end
            @(negedge clk);
            n++;
        end
        verify_count("pxl_cen per line", strobes, H_TOTAL);
        verify_count("lhbl low per line", lhbl_low, H_TOTAL - H_BLANK_START);
        verify_count("hs high per line", hs_high, HS_END - HS_START);
        verify_count("lines per frame", lines, V_TOTAL);
        verify_count("lvbl high lines", lvbl_high, V_BLANK_START);
        verify_count("vs high lines", vs_high, VS_END - VS_START);
        close_test("video_timing", e0);
    endtask

    //////////////////////////////
    // Sequence
    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        tb_ack      = 1'b0;
        char_cs     = 1'b0;
        char_addr   = '0;
        scroll_cs   = 1'b0;
        scroll_addr = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        sound_cs    = 1'b0;
        sound_addr  = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        download_mapping();
        single_miss();
        cache_hit();
        contention();
        video_timing();

        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/tora_pkg.sv
hdl/cen_gen.sv
hdl/video_timer.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/prog_loader.sv
hdl/tora_game.sv
tests/tora_chk.sv
tests/tb_tora.sv

// File: Makefile
# Verilator build and run for the frame services testbench

TOP := tb_tora
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
